/* hw/memByteSequencer.sv */
`default_nettype none

`include "memCtrl_defines.svh"

module memByteSequencer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,

    input  logic                 i_jobValid,
    input  memCtrl_pkg::memOpE   i_jobOp,
    input  memCtrl_pkg::addrT    i_jobAddr,
    input  memCtrl_pkg::lenT     i_jobLen,
    input  memCtrl_pkg::wordT    i_jobWdata,

    output memCtrl_pkg::addrT    o_memAddr,
    output logic                 o_memWrite,
    output memCtrl_pkg::byteT    o_memWdata,

    output logic                 o_tagValid,
    output memCtrl_pkg::byteIdxT o_tagIdx,
    output logic                 o_tagLast
);

    import memCtrl_pkg::*;

    lenT     issueCnt;
    byteIdxT issueIdx;
    logic    moreBytes;
    logic    issue;
    logic    lastByte;

    // bytes already issued for the current job
    assign issueIdx  = issueCnt[`BYTE_IDX_W-1:0];
    assign moreBytes = issueCnt != i_jobLen;
    assign lastByte  = issueCnt == (i_jobLen - lenT'(1));

    // one byte per cycle while the bus is ready
    assign issue = i_jobValid && i_rdy && moreBytes;

    always_ff @(posedge clk) begin
        if (rst) begin
            issueCnt <= '0;
        end else if (!i_jobValid) begin
            issueCnt <= '0;
        end else if (issue) begin
            issueCnt <= issueCnt + lenT'(1);
        end
    end

    // RAM port walks upward from the job address
    assign o_memAddr  = i_jobAddr + addrT'(issueCnt);
    assign o_memWdata = i_jobWdata[issueIdx*`BYTE_W +: `BYTE_W];
    assign o_memWrite = issue && (i_jobOp == opStore);

    // tag lines up with the read data one cycle later
    always_ff @(posedge clk) begin
        if (rst) begin
            o_tagValid <= 1'b0;
            o_tagLast  <= 1'b0;
        end else begin
            o_tagValid <= issue;
            o_tagLast  <= issue && lastByte;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            o_tagIdx <= issueIdx;
        end
    end

endmodule

`default_nettype wire

/* hw/memCtrl.sv */
`default_nettype none

module memCtrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 i_rdy,

    input  logic                 i_fetchEn,
    input  memCtrl_pkg::addrT    i_fetchAddr,
    output logic                 o_fetchDone,
    output memCtrl_pkg::wordT    o_fetchInst,

    input  logic                 i_dataEn,
    input  logic                 i_dataStore,
    input  memCtrl_pkg::lenT     i_dataLen,
    input  memCtrl_pkg::addrT    i_dataAddr,
    input  memCtrl_pkg::wordT    i_dataWdata,
    output logic                 o_dataDone,
    output memCtrl_pkg::wordT    o_dataRdata,

    output memCtrl_pkg::addrT    o_memAddr,
    output logic                 o_memWrite,
    output memCtrl_pkg::byteT    o_memWdata,
    input  memCtrl_pkg::byteT    i_memRdata
);

    import memCtrl_pkg::*;

    // latched job
    logic    jobValid;
    memOpE   jobOp;
    addrT    jobAddr;
    lenT     jobLen;
    wordT    jobWdata;
    logic    jobDone;

    // read tags from the sequencer
    logic    tagValid;
    byteIdxT tagIdx;
    logic    tagLast;

    memRequestArbiter i_memRequestArbiter (
        .clk         (clk),
        .rst         (rst),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .i_jobDone   (jobDone),
        .o_jobValid  (jobValid),
        .o_jobOp     (jobOp),
        .o_jobAddr   (jobAddr),
        .o_jobLen    (jobLen),
        .o_jobWdata  (jobWdata)
    );

    memByteSequencer i_memByteSequencer (
        .clk        (clk),
        .rst        (rst),
        .i_rdy      (i_rdy),
        .i_jobValid (jobValid),
        .i_jobOp    (jobOp),
        .i_jobAddr  (jobAddr),
        .i_jobLen   (jobLen),
        .i_jobWdata (jobWdata),
        .o_memAddr  (o_memAddr),
        .o_memWrite (o_memWrite),
        .o_memWdata (o_memWdata),
        .o_tagValid (tagValid),
        .o_tagIdx   (tagIdx),
        .o_tagLast  (tagLast)
    );

    memWordAssembler i_memWordAssembler (
        .clk         (clk),
        .rst         (rst),
        .i_jobOp     (jobOp),
        .i_tagValid  (tagValid),
        .i_tagIdx    (tagIdx),
        .i_tagLast   (tagLast),
        .i_memRdata  (i_memRdata),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .o_jobDone   (jobDone)
    );

endmodule

`default_nettype wire

/* hw/memCtrl_defines.svh */
`ifndef MEMCTRL_DEFINES_SVH
`define MEMCTRL_DEFINES_SVH

// byte address into the shared RAM
`define MEM_ADDR_W 32

// instruction and data word
`define WORD_W 32

// the RAM is one byte wide
`define BYTE_W 8

// an instruction always takes four RAM reads
`define FETCH_BYTES 4

// holds a count of 1, 2 or 4
`define LEN_W 3

// lane of a byte inside a word
`define BYTE_IDX_W 2

`endif

/* hw/memCtrl_pkg.sv */
`default_nettype none

package memCtrl_pkg;

    `include "memCtrl_defines.svh"

    // byte address
    typedef logic [`MEM_ADDR_W-1:0] addrT;

    // instruction or data word
    typedef logic [`WORD_W-1:0] wordT;

    // one RAM byte
    typedef logic [`BYTE_W-1:0] byteT;

    // number of bytes in a job
    typedef logic [`LEN_W-1:0] lenT;

    // lane 0 of a word holds the lowest address
    typedef logic [`BYTE_IDX_W-1:0] byteIdxT;

    // kind of job held by the arbiter
    typedef enum logic [1:0] {
        opFetch = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2
    } memOpE;

endpackage

`default_nettype wire

/* hw/memRequestArbiter.sv */
`default_nettype none

`include "memCtrl_defines.svh"

module memRequestArbiter (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 i_fetchEn,
    input  memCtrl_pkg::addrT    i_fetchAddr,

    input  logic                 i_dataEn,
    input  logic                 i_dataStore,
    input  memCtrl_pkg::lenT     i_dataLen,
    input  memCtrl_pkg::addrT    i_dataAddr,
    input  memCtrl_pkg::wordT    i_dataWdata,

    input  logic                 i_jobDone,

    output logic                 o_jobValid,
    output memCtrl_pkg::memOpE   o_jobOp,
    output memCtrl_pkg::addrT    o_jobAddr,
    output memCtrl_pkg::lenT     o_jobLen,
    output memCtrl_pkg::wordT    o_jobWdata
);

    import memCtrl_pkg::*;

    logic  jobValid;
    logic  reqPending;
    memOpE reqOp;
    addrT  reqAddr;
    lenT   reqLen;
    wordT  reqWdata;

    assign reqPending = i_dataEn || i_fetchEn;

    // data port has priority over fetch
    always_comb begin
        if (i_dataEn) begin
            reqOp    = i_dataStore ? opStore : opLoad;
            reqAddr  = i_dataAddr;
            reqLen   = i_dataLen;
            reqWdata = i_dataWdata;
        end else begin
            reqOp    = opFetch;
            reqAddr  = i_fetchAddr;
            reqLen   = lenT'(`FETCH_BYTES);
            reqWdata = '0;
        end
    end

    // job stays valid through the done cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            jobValid <= 1'b0;
        end else if (jobValid) begin
            if (i_jobDone) begin
                jobValid <= 1'b0;
            end
        end else if (reqPending) begin
            jobValid <= 1'b1;
        end
    end

    // job fields only load while idle
    always_ff @(posedge clk) begin
        if (!jobValid && reqPending) begin
            o_jobOp    <= reqOp;
            o_jobAddr  <= reqAddr;
            o_jobLen   <= reqLen;
            o_jobWdata <= reqWdata;
        end
    end

    assign o_jobValid = jobValid;

endmodule

`default_nettype wire

/* hw/memWordAssembler.sv */
`default_nettype none

`include "memCtrl_defines.svh"

module memWordAssembler (
    input  logic                 clk,
    input  logic                 rst,

    input  memCtrl_pkg::memOpE   i_jobOp,

    input  logic                 i_tagValid,
    input  memCtrl_pkg::byteIdxT i_tagIdx,
    input  logic                 i_tagLast,

    input  memCtrl_pkg::byteT    i_memRdata,

    output logic                 o_fetchDone,
    output memCtrl_pkg::wordT    o_fetchInst,
    output logic                 o_dataDone,
    output memCtrl_pkg::wordT    o_dataRdata,
    output logic                 o_jobDone
);

    import memCtrl_pkg::*;

    wordT asmWord;
    wordT nextWord;
    logic fetchDone;
    logic dataDone;

    // lane 0 starts a fresh word so short loads come back zero-extended
    always_comb begin
        nextWord = (i_tagIdx == '0) ? '0 : asmWord;
        nextWord[i_tagIdx*`BYTE_W +: `BYTE_W] = i_memRdata;
    end

    always_ff @(posedge clk) begin
        if (i_tagValid) begin
            asmWord <= nextWord;
        end
    end

    // done follows the last tag by one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            fetchDone <= i_tagValid && i_tagLast && (i_jobOp == opFetch);
            dataDone  <= i_tagValid && i_tagLast && (i_jobOp != opFetch);
        end
    end

    assign o_fetchDone = fetchDone;
    assign o_dataDone  = dataDone;
    assign o_jobDone   = fetchDone || dataDone;

    // word is complete by the time either strobe rises
    assign o_fetchInst = asmWord;
    assign o_dataRdata = asmWord;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f tb.f --top-module memCtrlTb -o memCtrlSim || exit 1
./obj_dir/memCtrlSim > sim.log 2>&1
cat sim.log
grep -q '^=== PASS ===$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* tb.f */
+incdir+hw
hw/memCtrl_pkg.sv
hw/memRequestArbiter.sv
hw/memByteSequencer.sv
hw/memWordAssembler.sv
hw/memCtrl.sv
testbench/ramModel.sv
testbench/memCtrl_sva.sv
testbench/memCtrl_tb.sv

/* testbench/memCtrl_sva.sv */
`default_nettype none

module memCtrlSva (
    input logic clk,
    input logic rst,
    input logic i_rdy,
    input logic i_fetchDone,
    input logic i_dataDone,
    input logic i_memWrite
);

    // only one client finishes at a time
    aDoneExclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_fetchDone && i_dataDone))
        else $error("fetch and data done strobes high in the same cycle");

    aFetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        i_fetchDone |=> !i_fetchDone)
        else $error("fetch done strobe longer than one cycle");

    aDataDonePulse: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |=> !i_dataDone)
        else $error("data done strobe longer than one cycle");

    // paused bus means no writes
    aNoWriteWhenPaused: assert property (@(posedge clk) disable iff (rst)
        !i_rdy |-> !i_memWrite)
        else $error("RAM write issued while i_rdy is low");

endmodule

bind memCtrl memCtrlSva i_memCtrlSva (
    .clk         (clk),
    .rst         (rst),
    .i_rdy       (i_rdy),
    .i_fetchDone (o_fetchDone),
    .i_dataDone  (o_dataDone),
    .i_memWrite  (o_memWrite)
);

`default_nettype wire

/* testbench/memCtrl_tb.sv */
`default_nettype none

`include "memCtrl_defines.svh"

module memCtrlTb;

    import memCtrl_pkg::*;

    localparam int numDirected = 13;
    localparam int numRandom   = 200;
    // forty cycles per request covers the worst i_rdy pauses
    localparam int cycleLimit  = (numDirected + numRandom) * 40;

    logic clk;
    logic rst;
    logic i_rdy = 1'b1;
    logic i_fetchEn;
    addrT i_fetchAddr;
    logic o_fetchDone;
    wordT o_fetchInst;
    logic i_dataEn;
    logic i_dataStore;
    lenT  i_dataLen;
    addrT i_dataAddr;
    wordT i_dataWdata;
    logic o_dataDone;
    wordT o_dataRdata;
    addrT o_memAddr;
    logic o_memWrite;
    byteT o_memWdata;
    byteT i_memRdata;

    // expected RAM contents
    byteT shadow [0:4095];

    int   cycleCnt  = 0;
    logic rdyRandom = 1'b0;

    // outstanding fetch
    logic  fetchPending = 1'b0;
    string fetchName;
    addrT  fetchAddrExp;
    int    fetchLat;
    int    fetchStart;
    int    fetchDoneAt;

    // outstanding data access
    logic  dataPending = 1'b0;
    string dataName;
    logic  dataIsStore;
    addrT  dataAddrExp;
    lenT   dataLenExp;
    int    dataLat;
    int    dataStart;
    int    dataDoneAt;

    memCtrl i_memCtrl (
        .clk         (clk),
        .rst         (rst),
        .i_rdy       (i_rdy),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWdata (i_dataWdata),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata),
        .o_memAddr   (o_memAddr),
        .o_memWrite  (o_memWrite),
        .o_memWdata  (o_memWdata),
        .i_memRdata  (i_memRdata)
    );

    ramModel i_ramModel (
        .clk     (clk),
        .i_addr  (o_memAddr),
        .i_write (o_memWrite),
        .i_wdata (o_memWdata),
        .o_rdata (i_memRdata)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // little-endian with the unread lanes left zero
    function automatic wordT refWord(input addrT addr, input lenT len);
        wordT w;
        addrT a;
        w = '0;
        for (int i = 0; i < int'(len); i++) begin
            a = addr + addrT'(i);
            w = w | (wordT'(shadow[a[11:0]]) << (`BYTE_W * i));
        end
        return w;
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkWord(input string name, input wordT exp, input wordT act);
        if (act !== exp) begin
            abortRun($sformatf("ERR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic checkDoneCycle(input string name, input int exp, input int act);
        if (act != exp) begin
            abortRun($sformatf("ERR %s: expected done at A+%0d, actual A+%0d", name, exp, act));
        end
    endtask

    task automatic checkLevel(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abortRun($sformatf("ERR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic checkResetState(input string name);
        checkLevel({name, " fetch done"}, 1'b0, o_fetchDone);
        checkLevel({name, " data done"}, 1'b0, o_dataDone);
        checkLevel({name, " mem write"}, 1'b0, o_memWrite);
    endtask

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= cycleLimit) begin
            abortRun($sformatf("timeout, run not finished after %0d cycles", cycleCnt));
        end
    end

    always @(posedge clk) begin
        if (rdyRandom) begin
            i_rdy <= ($urandom_range(3) != 0);
        end else begin
            i_rdy <= 1'b1;
        end
    end

    // compare on every done strobe
    always @(posedge clk) begin
        if (o_fetchDone === 1'b1) begin
            if (!fetchPending) begin
                abortRun("fetch done strobe seen while no fetch was outstanding");
            end else begin
                checkWord(fetchName, refWord(fetchAddrExp, lenT'(`FETCH_BYTES)), o_fetchInst);
                if (fetchLat >= 0) begin
                    checkDoneCycle(fetchName, fetchLat, cycleCnt - fetchStart - 1);
                end
                fetchDoneAt = cycleCnt;
            end
        end
        if (o_dataDone === 1'b1) begin
            if (!dataPending) begin
                abortRun("data done strobe seen while no data access was outstanding");
            end else begin
                if (!dataIsStore) begin
                    checkWord(dataName, refWord(dataAddrExp, dataLenExp), o_dataRdata);
                end
                if (dataLat >= 0) begin
                    checkDoneCycle(dataName, dataLat, cycleCnt - dataStart - 1);
                end
                dataDoneAt = cycleCnt;
            end
        end
    end

    task automatic fetchRequest(input string name, input addrT addr, input logic checkTime);
        fetchName    = name;
        fetchAddrExp = addr;
        fetchLat     = checkTime ? `FETCH_BYTES + 2 : -1;
        @(posedge clk);
        fetchStart = cycleCnt;
        fetchPending <= 1'b1;
        i_fetchEn    <= 1'b1;
        i_fetchAddr  <= addr;
        @(posedge clk);
        while (o_fetchDone !== 1'b1) begin
            @(posedge clk);
        end
        fetchPending <= 1'b0;
        i_fetchEn    <= 1'b0;
        @(posedge clk);
    endtask

    task automatic dataRequest(input string name, input logic store, input lenT len,
                               input addrT addr, input wordT wdata, input logic checkTime);
        addrT a;
        // shadow takes the new bytes as soon as the store is issued
        if (store) begin
            for (int i = 0; i < int'(len); i++) begin
                a = addr + addrT'(i);
                shadow[a[11:0]] = byteT'(wdata >> (`BYTE_W * i));
            end
        end
        dataName    = name;
        dataIsStore = store;
        dataAddrExp = addr;
        dataLenExp  = len;
        dataLat     = checkTime ? int'(len) + 2 : -1;
        @(posedge clk);
        dataStart = cycleCnt;
        dataPending <= 1'b1;
        i_dataEn    <= 1'b1;
        i_dataStore <= store;
        i_dataLen   <= len;
        i_dataAddr  <= addr;
        i_dataWdata <= wdata;
        @(posedge clk);
        while (o_dataDone !== 1'b1) begin
            @(posedge clk);
        end
        dataPending <= 1'b0;
        i_dataEn    <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        wordT wdata;
        addrT addr;
        lenT  len;
        int   kind;
        void'($urandom(32'h2de42aae));
        rst         = 1'b1;
        i_fetchEn   = 1'b0;
        i_fetchAddr = '0;
        i_dataEn    = 1'b0;
        i_dataStore = 1'b0;
        i_dataLen   = '0;
        i_dataAddr  = '0;
        i_dataWdata = '0;

        @(posedge clk);
        repeat (2) begin
            @(posedge clk);
            checkResetState("during reset");
        end
        rst <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            checkResetState("after reset");
        end
        for (int a = 0; a < 4096; a++) begin
            shadow[a[11:0]] = i_ramModel.mem[a[11:0]];
        end

        fetchRequest("fetch 0x100", 32'h0000_0100, 1'b1);
        fetchRequest("fetch across wrap", 32'h0000_0ffe, 1'b1);
        dataRequest("load len 1", 1'b0, 3'd1, 32'h0000_0203, '0, 1'b1);
        dataRequest("load len 2", 1'b0, 3'd2, 32'h0000_0301, '0, 1'b1);
        dataRequest("load len 4", 1'b0, 3'd4, 32'h0000_0402, '0, 1'b1);

        dataRequest("store len 1", 1'b1, 3'd1, 32'h0000_0500, 32'hdeadbeef, 1'b1);
        dataRequest("reload after store 1", 1'b0, 3'd4, 32'h0000_0500, '0, 1'b1);
        dataRequest("store len 2", 1'b1, 3'd2, 32'h0000_0601, 32'h1234abcd, 1'b1);
        dataRequest("reload after store 2", 1'b0, 3'd4, 32'h0000_0601, '0, 1'b1);
        dataRequest("store len 4", 1'b1, 3'd4, 32'h0000_0702, 32'hcafef00d, 1'b1);
        dataRequest("reload after store 4", 1'b0, 3'd4, 32'h0000_0702, '0, 1'b1);

        // fetch waits behind the store and must see the stored word
        fork
            dataRequest("store beside fetch", 1'b1, 3'd4, 32'h0000_0800, 32'h13579bdf, 1'b1);
            fetchRequest("fetch beside store", 32'h0000_0800, 1'b0);
        join
        if (dataDoneAt >= fetchDoneAt) begin
            abortRun("fetch finished before the data request raised in the same cycle");
        end

        rdyRandom <= 1'b1;
        for (int n = 0; n < numRandom; n++) begin
            kind  = $urandom_range(2);
            addr  = $urandom();
            wdata = $urandom();
            case ($urandom_range(2))
                0: len = 3'd1;
                1: len = 3'd2;
                default: len = 3'd4;
            endcase
            if (kind == 0) begin
                fetchRequest($sformatf("random fetch %0d", n), addr, 1'b0);
            end else begin
                dataRequest($sformatf("random data %0d", n), kind == 2, len, addr, wdata, 1'b0);
            end
        end
        rdyRandom <= 1'b0;
        repeat (4) @(posedge clk);

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/ramModel.sv */
`default_nettype none

module ramModel (
    input  logic              clk,
    input  memCtrl_pkg::addrT i_addr,
    input  logic              i_write,
    input  memCtrl_pkg::byteT i_wdata,
    output memCtrl_pkg::byteT o_rdata
);

    import memCtrl_pkg::*;

    // 4096 bytes with the upper address bits ignored
    byteT mem [0:4095];

    // pattern mixes all twelve address bits
    initial begin
        for (int a = 0; a < 4096; a++) begin
            mem[a[11:0]] = byteT'((a * 7) ^ (a >> 4) ^ 'h5a);
        end
    end

    // read data shows up the cycle after the address
    always @(posedge clk) begin
        if (i_write) begin
            mem[i_addr[11:0]] <= i_wdata;
        end
        o_rdata <= mem[i_addr[11:0]];
    end

endmodule

`default_nettype wire
